// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DFT input memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f verilog.f --top-module mrd_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vmrd_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

// ==== source/mrd_bank_ram.sv ====
/*
 * One sample bank
 * Simple dual-port RAM holding {real, imag}, registered read
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_bank_ram (
	input  logic                      clk,
	input  logic                      wren,
	input  logic [`MRD_BANK_AW-1:0]   wraddr,
	input  logic [2*`MRD_DATA_W-1:0]  din,
	input  logic [`MRD_BANK_AW-1:0]   rdaddr,
	output logic [2*`MRD_DATA_W-1:0]  dout
);

	logic [2*`MRD_DATA_W-1:0] mem [1 << `MRD_BANK_AW];

	always_ff @(posedge clk)
	begin
		if (wren)
			mem[wraddr] <= din;
		dout <= mem[rdaddr]; // Old data on a same-address collision
	end

endmodule

`default_nettype wire

// ==== source/mrd_config.svh ====
/*
 * Mixed radix DFT input memory, build-time sizes
 * Sample width, bank layout and frame size widths
 */
`ifndef MRD_CONFIG_SVH
`define MRD_CONFIG_SVH

// Sample component width, real and imaginary alike
`define MRD_DATA_W 18

// ---------------------------------------------------------------------------
// Bank layout
// ---------------------------------------------------------------------------
`define MRD_BANKS 7
`define MRD_BANK_AW 8 // 256 words per bank

// Frame length, up to 7 x 256 = 1792 points
`define MRD_PTS_W 12

// One PFA factor and one residue
`define MRD_NF_W 4
`define MRD_RES_W 4

`endif

// ==== source/mrd_ctrl.sv ====
/*
 * Input memory control
 * Idle, sink and source sequencing; holds factors and length per frame
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_ctrl
	import mrd_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_sop,
	input  mrd_factors_t          in_factors,
	input  logic [`MRD_PTS_W-1:0] in_dftpts,
	input  mrd_stat_t             stat,
	output mrd_state_e            state,
	output mrd_factors_t          nf,
	output logic [`MRD_PTS_W-1:0] dftpts
);

	mrd_state_e   state_nxt;
	mrd_factors_t nf_q;
	logic         frame_start;

	assign frame_start = in_sop && (state == ST_IDLE);

	// Input factors pass through while idle so the sop sample counts with them
	assign nf = (state == ST_IDLE) ? in_factors : nf_q;

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (frame_start)
					state_nxt = ST_SINK;
			ST_SINK:
				if (!stat.sink_ongoing)
					state_nxt = ST_SOURCE;
			ST_SOURCE: // Reads done and every point delivered
				if (!stat.source_ongoing && (stat.dftpts == dftpts))
					state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state  <= ST_IDLE;
			nf_q   <= '0;
			dftpts <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (frame_start)
			begin
				nf_q   <= in_factors;
				dftpts <= in_dftpts;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/mrd_div7.sv ====
/*
 * Divide by seven
 * Reciprocal multiply, then one correction step
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_div7 (
	input  logic [`MRD_PTS_W-1:0] dividend,
	output logic [`MRD_PTS_W-1:0] quotient,
	output logic [2:0]            remainder
);

	localparam int W = `MRD_PTS_W;
	localparam int SHIFT = 14;             // Enough for a 12-bit dividend
	localparam logic [W-1:0] RECIP = W'(2340); // floor(2^14 / 7), low by design

	logic [2*W-1:0] prod;
	logic [W-1:0]   q_est;
	logic [W-1:0]   r_est;

	// Estimate is exact or one short
	assign prod  = (2*W)'(dividend) * (2*W)'(RECIP);
	assign q_est = W'(prod >> SHIFT);
	assign r_est = dividend - q_est * W'(7);

	always_comb
	begin
		if (r_est >= W'(7))
		begin
			quotient  = q_est + 1'b1;
			remainder = 3'(r_est - W'(7));
		end
		else
		begin
			quotient  = q_est;
			remainder = r_est[2:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/mrd_mem_top.sv ====
/*
 * Input memory of the mixed radix DFT
 * Sink writes each sample to its PFA slot over seven banks,
 * source reads the frame back in PFA order
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_mem_top
	import mrd_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  mrd_sample_t           in_data,
	input  mrd_state_e            state,
	input  mrd_factors_t          nf,
	input  logic [`MRD_PTS_W-1:0] dftpts,
	output mrd_sample_t           out_data,
	output mrd_stat_t             stat
);

	localparam int PW = `MRD_PTS_W;
	localparam int DW = `MRD_DATA_W;
	localparam int AW = `MRD_BANK_AW;
	localparam int NB = `MRD_BANKS;
	localparam int SW = $clog2(`MRD_BANKS);

	logic                  sop_go;
	logic                  accept;
	logic                  sink_open;
	logic                  sink_ongoing;
	logic [`MRD_RES_W-1:0] n1;
	logic [`MRD_RES_W-1:0] n2;
	logic [`MRD_RES_W-1:0] n3;
	logic [PW-1:0]         pfa_idx;
	logic                  s1_valid;
	logic                  s1_eop;
	logic [PW-1:0]         s1_idx;
	logic [2*DW-1:0]       s1_data;
	logic [PW-1:0]         wr_quot;
	logic [SW-1:0]         wr_bank;
	logic [NB-1:0]         wr_onehot;
	logic [NB-1:0]         s2_wren;
	logic                  s2_last;
	logic [AW-1:0]         s2_addr;
	logic [2*DW-1:0]       s2_data;
	logic                  rd_active;
	logic                  rd_last;
	logic [PW-1:0]         rd_cnt;
	logic [PW-1:0]         rd_quot;
	logic [SW-1:0]         rd_bank;
	logic                  r1_valid;
	logic                  r1_sop;
	logic                  r1_eop;
	logic [SW-1:0]         r1_bank;
	logic [2*DW-1:0]       bank_dout [NB];
	logic                  out_valid;
	logic                  out_sop;
	logic                  out_eop;
	logic [DW-1:0]         out_real;
	logic [DW-1:0]         out_imag;
	logic [PW-1:0]         out_cnt;

	// ------------------------------------------------------------------------
	// Sink path
	// ------------------------------------------------------------------------
	assign sop_go = in_data.sop && (state == ST_IDLE);
	assign accept = sop_go || (in_data.valid && sink_open && (state == ST_SINK));

	mrd_pfa_addr_gen u_pfa_addr_gen (
		.clk   (clk),
		.rst_n (rst_n),
		.clr   ((state != ST_SINK) && !sop_go),
		.step  (accept),
		.nf    (nf),
		.n1    (n1),
		.n2    (n2),
		.n3    (n3)
	);

	// P = n1*N2*N3 + n2*N3 + n3
	assign pfa_idx = PW'(n1) * (PW'(nf.nf2) * PW'(nf.nf3))
	               + PW'(n2) * PW'(nf.nf3) + PW'(n3);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			s1_valid  <= 1'b0;
			s1_eop    <= 1'b0;
			s2_wren   <= '0;
			s2_last   <= 1'b0;
			sink_open <= 1'b0;
			sink_ongoing <= 1'b0;
		end
		else
		begin
			s1_valid <= accept;
			s1_eop   <= accept && in_data.eop;
			s2_wren  <= wr_onehot;
			s2_last  <= s1_eop;

			if (sop_go)
				sink_open <= !in_data.eop;
			else if (accept && in_data.eop)
				sink_open <= 1'b0; // Late samples are dropped

			if (s2_last)
				sink_ongoing <= 1'b0; // eop sample written this edge
			else if (sop_go)
				sink_ongoing <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_idx  <= pfa_idx;
		s1_data <= {in_data.d_real, in_data.d_imag};
		s2_addr <= wr_quot[AW-1:0];
		s2_data <= s1_data;
	end

	mrd_div7 u_div7_sink (
		.dividend  (s1_idx),
		.quotient  (wr_quot),
		.remainder (wr_bank)
	);

	always_comb
	begin
		wr_onehot = '0;
		if (s1_valid)
			wr_onehot[wr_bank] = 1'b1;
	end

	for (genvar i = 0; i < NB; i++)
	begin : g_bank
		mrd_bank_ram u_bank (
			.clk    (clk),
			.wren   (s2_wren[i] && (state == ST_SINK)),
			.wraddr (s2_addr),
			.din    (s2_data),
			.rdaddr (rd_quot[AW-1:0]),
			.dout   (bank_dout[i])
		);
	end

	// ------------------------------------------------------------------------
	// Source path
	// ------------------------------------------------------------------------
	assign rd_last = (rd_cnt == dftpts - 1'b1);

	mrd_div7 u_div7_source (
		.dividend  (rd_cnt),
		.quotient  (rd_quot),
		.remainder (rd_bank)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_active <= 1'b0;
			rd_cnt    <= '0;
			r1_valid  <= 1'b0;
			r1_sop    <= 1'b0;
			r1_eop    <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
			out_cnt   <= '0;
		end
		else
		begin
			// Same edge on which control enters ST_SOURCE
			if ((state == ST_SINK) && !sink_ongoing)
				rd_active <= 1'b1;
			else if (rd_active && rd_last)
				rd_active <= 1'b0;

			if (rd_active)
				rd_cnt <= rd_last ? '0 : rd_cnt + 1'b1;

			r1_valid  <= rd_active;
			r1_sop    <= rd_active && (rd_cnt == '0);
			r1_eop    <= rd_active && rd_last;
			out_valid <= r1_valid;
			out_sop   <= r1_sop;
			out_eop   <= r1_eop;

			if (state == ST_IDLE)
				out_cnt <= '0;
			else if (out_valid)
				out_cnt <= out_cnt + 1'b1;
		end
	end

	// Bank select follows the registered read
	always_ff @(posedge clk)
	begin
		r1_bank <= rd_bank;
		{out_real, out_imag} <= bank_dout[r1_bank];
	end

	assign out_data = '{valid: out_valid, sop: out_sop, eop: out_eop,
	                    d_real: out_real, d_imag: out_imag};

	assign stat = '{sink_ongoing: sink_ongoing, source_ongoing: rd_active,
	                dftpts: out_cnt};

endmodule

`default_nettype wire

// ==== source/mrd_pfa_addr_gen.sv ====
/*
 * PFA residue generator
 * Tracks n mod N1, n mod N2 and n mod N3 of the running sample index
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_pfa_addr_gen
	import mrd_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  clr,
	input  logic                  step,
	input  mrd_factors_t          nf,
	output logic [`MRD_RES_W-1:0] n1,
	output logic [`MRD_RES_W-1:0] n2,
	output logic [`MRD_RES_W-1:0] n3
);

	localparam int RW = `MRD_RES_W;
	localparam int NW = `MRD_NF_W;

	// Next value of one residue counter, wraps at its factor
	function automatic logic [RW-1:0] res_next(
		input logic [RW-1:0] cur,
		input logic [NW-1:0] fac
	);
		logic [RW-1:0] inc;

		inc = cur + 1'b1;
		if (NW'(inc) == fac)
			res_next = '0;
		else
			res_next = inc;
	endfunction

	// ------------------------------------------------------------------------
	// Residue counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			n1 <= '0;
			n2 <= '0;
			n3 <= '0;
		end
		else if (clr) // Frame boundary wins over step
		begin
			n1 <= '0;
			n2 <= '0;
			n3 <= '0;
		end
		else if (step)
		begin
			n1 <= res_next(n1, nf.nf1);
			n2 <= res_next(n2, nf.nf2);
			n3 <= res_next(n3, nf.nf3);
		end
	end

endmodule

`default_nettype wire

// ==== source/mrd_pkg.sv ====
/*
 * Mixed radix DFT input memory types
 * Sample strobe, factor set, memory status and control states
 */
`default_nettype none

`include "mrd_config.svh"

package mrd_pkg;

	// One sample with its framing strobes
	typedef struct packed
	{
		logic valid;
		logic sop;
		logic eop;
		logic [`MRD_DATA_W-1:0] d_real;
		logic [`MRD_DATA_W-1:0] d_imag;
	} mrd_sample_t;

	// Coprime factors N1, N2, N3 of the frame length
	typedef struct packed
	{
		logic [`MRD_NF_W-1:0] nf1;
		logic [`MRD_NF_W-1:0] nf2;
		logic [`MRD_NF_W-1:0] nf3;
	} mrd_factors_t;

	// Memory to control
	typedef struct packed
	{
		logic sink_ongoing;
		logic source_ongoing;
		logic [`MRD_PTS_W-1:0] dftpts; // Points delivered so far
	} mrd_stat_t;

	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,
		ST_SINK   = 2'd1,
		ST_SOURCE = 2'd2
	} mrd_state_e;

endpackage

`default_nettype wire

// ==== source/mrd_top.sv ====
/*
 * Mixed radix DFT input memory, top level
 * Control FSM and banked PFA memory
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_top
	import mrd_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  mrd_sample_t           in_data,
	input  mrd_factors_t          in_factors,
	input  logic [`MRD_PTS_W-1:0] in_dftpts,
	output mrd_sample_t           out_data
);

	mrd_state_e            state;
	mrd_factors_t          nf;
	logic [`MRD_PTS_W-1:0] dftpts;
	mrd_stat_t             stat;

	// ------------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------------
	mrd_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_sop     (in_data.sop),
		.in_factors (in_factors),
		.in_dftpts  (in_dftpts),
		.stat       (stat),
		.state      (state),
		.nf         (nf),
		.dftpts     (dftpts)
	);

	// ------------------------------------------------------------------------
	// Memory
	// ------------------------------------------------------------------------
	mrd_mem_top u_mem_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.state    (state),
		.nf       (nf),
		.dftpts   (dftpts),
		.out_data (out_data),
		.stat     (stat)
	);

endmodule

`default_nettype wire

// ==== tests/mrd_assertions.sv ====
/*
 * Readback checker for the DFT input memory
 * PFA order, negated imaginary part, framing, latency and idle outputs
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_assertions
	import mrd_pkg::*;
(
	input logic                  clk,
	input logic                  rst_n,
	input mrd_sample_t           in_data,
	input mrd_factors_t          in_factors,
	input logic [`MRD_PTS_W-1:0] in_dftpts,
	input mrd_sample_t           out_data
);

	localparam int PW = `MRD_PTS_W;
	localparam int DW = `MRD_DATA_W;

	int            fail_cnt; // Failed checks so far
	logic          busy;     // Frame accepted, readback not finished
	logic          sink_ph;  // Between accepted sop and input eop
	logic          rb;       // Inside an output frame
	logic          rst_q;
	mrd_factors_t  fac;
	logic [PW-1:0] pts;
	logic [PW-1:0] k_q;
	logic [PW-1:0] k_now;
	logic          sop_acc;
	logic          in_eop_acc;
	logic [DW-1:0] neg_real;
	int            exp1;
	int            exp2;
	int            exp3;
	int            obs1;
	int            obs2;
	int            obs3;

	initial fail_cnt = 0;

	assign sop_acc    = in_data.sop && !busy;
	assign in_eop_acc = (sop_acc || sink_ph) && in_data.valid && in_data.eop;
	assign k_now      = out_data.sop ? '0 : k_q;
	assign neg_real   = '0 - out_data.d_real;

	// ------------------------------------------------------------------------
	// Frame tracking
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		rst_q <= rst_n;
		if (!rst_n)
		begin
			busy    <= 1'b0;
			sink_ph <= 1'b0;
			rb      <= 1'b0;
			fac     <= '0;
			pts     <= '0;
			k_q     <= '0;
		end
		else
		begin
			if (sop_acc)
			begin
				busy <= 1'b1;
				fac  <= in_factors;
				pts  <= in_dftpts;
			end
			else if (out_data.valid && out_data.eop)
				busy <= 1'b0;

			if (in_eop_acc)
				sink_ph <= 1'b0;
			else if (sop_acc)
				sink_ph <= 1'b1;

			if (out_data.valid && out_data.eop)
				rb <= 1'b0;
			else if (out_data.valid && out_data.sop)
				rb <= 1'b1;

			if (out_data.valid)
				k_q <= k_now + 1'b1;
		end
	end

	// Expected residues of output k, P = n1*N2*N3 + n2*N3 + n3
	always_comb
	begin
		exp1 = 0;
		exp2 = 0;
		exp3 = 0;
		obs1 = 0;
		obs2 = 0;
		obs3 = 0;
		if ((fac.nf1 != '0) && (fac.nf2 != '0) && (fac.nf3 != '0))
		begin
			exp1 = int'(k_now) / (int'(fac.nf2) * int'(fac.nf3));
			exp2 = (int'(k_now) / int'(fac.nf3)) % int'(fac.nf2);
			exp3 = int'(k_now) % int'(fac.nf3);
			obs1 = int'(out_data.d_real) % int'(fac.nf1);
			obs2 = int'(out_data.d_real) % int'(fac.nf2);
			obs3 = int'(out_data.d_real) % int'(fac.nf3);
		end
	end

	// ------------------------------------------------------------------------
	// Properties
	// ------------------------------------------------------------------------
	ap_residue: assert property (@(posedge clk) disable iff (!rst_n)
		out_data.valid |-> (obs1 == exp1) && (obs2 == exp2) && (obs3 == exp3)
			&& (out_data.d_real < DW'(pts)))
	else
	begin
		fail_cnt++;
		$error("[ERROR] %0t: sample out of PFA order at output %0d", $time, k_now);
	end

	ap_imag: assert property (@(posedge clk) disable iff (!rst_n)
		out_data.valid |-> out_data.d_imag == neg_real)
	else
	begin
		fail_cnt++;
		$error("[ERROR] %0t: imaginary part is not the negated real part", $time);
	end

	ap_count: assert property (@(posedge clk) disable iff (!rst_n)
		out_data.valid |-> out_data.eop == (k_now == pts - 1'b1))
	else
	begin
		fail_cnt++;
		$error("[ERROR] %0t: output eop not on sample N-1 of %0d", $time, pts);
	end

	ap_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_data.sop == $past(in_eop_acc, 6))
	else
	begin
		fail_cnt++;
		$error("[ERROR] %0t: output sop not 6 cycles after input eop", $time);
	end

	ap_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		(out_data.valid || out_data.sop || out_data.eop)
			|-> out_data.valid && (out_data.sop || rb))
	else
	begin
		fail_cnt++;
		$error("[ERROR] %0t: output strobe outside a frame readback", $time);
	end

	ap_reset_quiet: assert property (@(posedge clk)
		(!rst_n && !rst_q) |-> !out_data.valid)
	else
	begin
		fail_cnt++;
		$error("[ERROR] %0t: output valid during reset", $time);
	end

endmodule

bind mrd_top mrd_assertions u_mrd_assertions (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_data    (in_data),
	.in_factors (in_factors),
	.in_dftpts  (in_dftpts),
	.out_data   (out_data)
);

`default_nettype wire

// ==== tests/mrd_clk_gen.sv ====
/*
 * Testbench clock and reset
 * 20 ns clock, rst_n held low for the first 16 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module mrd_clk_gen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1; // Released in the drive slot after the edge
	end

endmodule

`default_nettype wire

// ==== tests/mrd_tb.sv ====
/*
 * Testbench for the mixed radix DFT input memory
 * Sends PFA frames and waits for each readback, bound assertions check it
 */
`timescale 1ns/10ps
`default_nettype none

`include "mrd_config.svh"

module mrd_tb
	import mrd_pkg::*;
();

	localparam int DW = `MRD_DATA_W;
	localparam int PW = `MRD_PTS_W;
	localparam int NW = `MRD_NF_W;
	localparam int TOTAL_PTS   = 60 + 360 + 105 + 84 + 30;
	localparam int CYCLE_LIMIT = TOTAL_PTS * 3 + 500;

	logic          clk;
	logic          rst_n;
	mrd_sample_t   in_data;
	mrd_factors_t  in_factors;
	logic [PW-1:0] in_dftpts;
	mrd_sample_t   out_data;
	int            cycle_cnt;
	int            tests_run;
	int            tests_failed;

	mrd_clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mrd_top u_mrd_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_data    (in_data),
		.in_factors (in_factors),
		.in_dftpts  (in_dftpts),
		.out_data   (out_data)
	);

	function automatic mrd_factors_t make_factors(input int a, input int b, input int c);
		mrd_factors_t f;

		f.nf1 = NW'(a);
		f.nf2 = NW'(b);
		f.nf3 = NW'(c);
		return f;
	endfunction

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_idle();
		in_data.valid  = 1'b0;
		in_data.sop    = 1'b0;
		in_data.eop    = 1'b0;
		in_data.d_real = '0;
		in_data.d_imag = '0;
	endtask

	// ------------------------------------------------------------------------
	// Frame stimulus, sample n carries n and -n
	// ------------------------------------------------------------------------
	task automatic send_frame(input int f1, input int f2, input int f3,
	                          input bit gaps, input int extra_at);
		int pts;
		int gap_len;

		pts = f1 * f2 * f3;
		for (int n = 0; n < pts; n++)
		begin
			if (gaps && (n > 0) && ($urandom_range(3, 0) == 0))
			begin
				gap_len = $urandom_range(2, 1);
				repeat (gap_len)
				begin
					drive_idle();
					next_cycle();
				end
			end
			in_data.valid  = 1'b1;
			in_data.sop    = (n == 0) || (n == extra_at);
			in_data.eop    = (n == pts - 1);
			in_data.d_real = DW'(n);
			in_data.d_imag = DW'(-n);
			if (n == 0)
			begin
				in_factors = make_factors(f1, f2, f3);
				in_dftpts  = PW'(pts);
			end
			else if (n == extra_at) // Foreign sop inside the sink phase
			begin
				in_factors = make_factors(8, 9, 5);
				in_dftpts  = PW'(360);
			end
			next_cycle();
		end
		drive_idle();
	endtask

	// Foreign sop a few cycles into the readback
	task automatic sop_during_source();
		bit seen;

		seen = 1'b0;
		while (!seen)
		begin
			next_cycle();
			seen = out_data.valid;
		end
		repeat (10) next_cycle();
		in_data.valid  = 1'b1;
		in_data.sop    = 1'b1;
		in_data.d_real = '1;
		in_data.d_imag = '1;
		in_factors     = make_factors(8, 9, 5);
		in_dftpts      = PW'(360);
		next_cycle();
		drive_idle();
	endtask

	task automatic wait_frame_out();
		bit seen_eop;

		seen_eop = 1'b0;
		while (!seen_eop)
		begin
			next_cycle();
			seen_eop = out_data.valid && out_data.eop;
		end
	endtask

	task automatic run_test(input int idx, input string name, input int f1, input int f2,
	                        input int f3, input bit gaps, input int extra_at,
	                        input bit src_sop, input int lead_idle);
		int errs_before;
		bit ok;

		errs_before = u_mrd_top.u_mrd_assertions.fail_cnt;
		repeat (lead_idle) next_cycle();
		send_frame(f1, f2, f3, gaps, extra_at);
		if (src_sop)
			sop_during_source();
		wait_frame_out();
		repeat (4) next_cycle(); // Control is back in idle two cycles after eop
		ok = (u_mrd_top.u_mrd_assertions.fail_cnt == errs_before);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("test %0d, %s: %s", idx, name, ok ? "pass" : "fail");
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		void'($urandom(32'h2128_1578));
		tests_run    = 0;
		tests_failed = 0;
		in_factors   = '0;
		in_dftpts    = '0;
		drive_idle();
		wait (rst_n === 1'b1);

		run_test(1, "60 points 4x3x5, contiguous", 4, 3, 5, 1'b0, -1, 1'b0, 2);
		run_test(2, "360 points 8x9x5, all banks", 8, 9, 5, 1'b0, -1, 1'b0, 2);
		run_test(3, "105 points 7x3x5, gaps in valid", 7, 3, 5, 1'b1, -1, 1'b0, 2);
		run_test(4, "84 points 4x7x3, foreign sop", 4, 7, 3, 1'b0, 40, 1'b1, 2);
		run_test(5, "30 points 2x3x5 after idle", 2, 3, 5, 1'b0, -1, 1'b0, 20);

		$display("%0d tests, %0d passed, %0d failed, %0d assertion failures", tests_run,
		         tests_run - tests_failed, tests_failed, u_mrd_top.u_mrd_assertions.fail_cnt);
		if ((tests_failed == 0) && (tests_run == 5)
		    && (u_mrd_top.u_mrd_assertions.fail_cnt == 0))
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog, limit from the summed frame lengths
	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the frames did not complete within %0d cycles", CYCLE_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/mrd_pkg.sv
source/mrd_pfa_addr_gen.sv
source/mrd_div7.sv
source/mrd_bank_ram.sv
source/mrd_mem_top.sv
source/mrd_ctrl.sv
source/mrd_top.sv
tests/mrd_clk_gen.sv
tests/mrd_assertions.sv
tests/mrd_tb.sv
